// File: src/l1d_pkg.sv
// Cache geometry, request and size codes and the cache line union
package l1d_pkg;

	// ----------------------------------------
	// Core and line geometry
	// ----------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int LINE_W = 128;

	localparam int LINE_BYTES = LINE_W / 8;
	localparam int LINE_WORDS = LINE_W / DATA_W;

	localparam int WAY_NUM = 4;
	localparam int SET_NUM = 64;

	// Address split as tag, index, offset
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int IDX_W    = $clog2(SET_NUM);
	localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;

	// ----------------------------------------
	// Request codes
	// ----------------------------------------
	localparam int COP_W = 2;

	localparam logic [COP_W-1:0] COP_RD   = 2'd0;
	localparam logic [COP_W-1:0] COP_WR   = 2'd1;
	localparam logic [COP_W-1:0] COP_RDNC = 2'd2;
	localparam logic [COP_W-1:0] COP_WRNC = 2'd3;

	// ----------------------------------------
	// Access size codes
	// ----------------------------------------
	localparam int SIZE_W = 3;

	// Value is the byte count
	localparam logic [SIZE_W-1:0] SIZE_B  = 3'd1;
	localparam logic [SIZE_W-1:0] SIZE_H  = 3'd2;
	localparam logic [SIZE_W-1:0] SIZE_W4 = 3'd4;

	// ----------------------------------------
	// Cache line
	// ----------------------------------------

	// Word view for the core response
	// Byte view for byte-enabled array writes
	typedef union packed {
		logic [LINE_WORDS-1:0][DATA_W-1:0] words;
		logic [LINE_BYTES-1:0][7:0]        bytes;
	} l1d_line_u;

endpackage

// File: src/l1d_arrays_if.sv
// Tag-array and data-array access interfaces
`timescale 1ns/1ps

interface l1d_tag_if;
	logic                        rd_en;
	logic [l1d_pkg::IDX_W-1:0]   rd_idx;
	logic [l1d_pkg::WAY_NUM-1:0] wr_way;
	logic [l1d_pkg::IDX_W-1:0]   wr_idx;
	logic [l1d_pkg::TAG_W-1:0]   wr_tag;
	logic [l1d_pkg::TAG_W-1:0]   cmp_tag;
	logic [l1d_pkg::WAY_NUM-1:0] hit_vect;
	logic [l1d_pkg::WAY_NUM-1:0] val_vect;
	logic                        ready;

	modport ctrl (
		output rd_en, rd_idx, wr_way, wr_idx, wr_tag, cmp_tag,
		input  hit_vect, val_vect, ready
	);

	modport mem (
		input  rd_en, rd_idx, wr_way, wr_idx, wr_tag, cmp_tag,
		output hit_vect, val_vect, ready
	);
endinterface

interface l1d_data_if;
	logic                                              rd_en;
	logic [l1d_pkg::IDX_W-1:0]                         rd_idx;
	logic [l1d_pkg::WAY_NUM-1:0]                       wr_way;
	logic [l1d_pkg::IDX_W-1:0]                         wr_idx;
	logic [l1d_pkg::LINE_BYTES-1:0]                    wr_be;
	l1d_pkg::l1d_line_u                                wr_line;
	l1d_pkg::l1d_line_u [l1d_pkg::WAY_NUM-1:0]         rd_lines;

	modport ctrl (
		output rd_en, rd_idx, wr_way, wr_idx, wr_be, wr_line,
		input  rd_lines
	);

	modport mem (
		input  rd_en, rd_idx, wr_way, wr_idx, wr_be, wr_line,
		output rd_lines
	);
endinterface

// File: src/l1d_tag_mem.sv
// Tag and valid storage for all ways with reset sweep and tag compare
`timescale 1ns/1ps

module l1d_tag_mem (
	input logic    clk,
	input logic    rst_n,
	l1d_tag_if.mem port
);

	logic [l1d_pkg::TAG_W-1:0]   tag_ram [l1d_pkg::WAY_NUM][l1d_pkg::SET_NUM];
	logic [l1d_pkg::WAY_NUM-1:0] val_ram [l1d_pkg::SET_NUM];

	logic [l1d_pkg::TAG_W-1:0]   rd_tag_r [l1d_pkg::WAY_NUM];
	logic [l1d_pkg::WAY_NUM-1:0] rd_val_r;

	logic [l1d_pkg::IDX_W-1:0]   sweep_idx;
	logic                        ready_r;

	// ----------------------------------------
	// Valid sweep after reset
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_idx <= '0;
			ready_r   <= 1'b0;
		end else if (!ready_r) begin
			sweep_idx <= sweep_idx + 1'b1;
			// Last set reached
			if (&sweep_idx)
				ready_r <= 1'b1;
		end
	end

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!ready_r) begin
			val_ram[sweep_idx] <= '0;
		end else begin
			for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
				if (port.wr_way[w])
					val_ram[port.wr_idx][w] <= 1'b1;
			end
		end
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (port.wr_way[w])
				tag_ram[w][port.wr_idx] <= port.wr_tag;
			if (port.rd_en)
				rd_tag_r[w] <= tag_ram[w][port.rd_idx];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_val_r <= '0;
		else if (port.rd_en)
			rd_val_r <= val_ram[port.rd_idx];
	end

	// Stage 1 compare against the registered read
	always_comb begin
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++)
			port.hit_vect[w] = (rd_tag_r[w] == port.cmp_tag);
	end

	assign port.val_vect = rd_val_r;
	assign port.ready    = ready_r;

	// A tag may live in one way of a set only
	one_hit_way_a: assert property (@(posedge clk) disable iff (!rst_n)
		ready_r |-> $onehot0(port.hit_vect & rd_val_r))
		else $error("Tag matches more than one valid way");

endmodule

// File: src/l1d_data_mem.sv
// Line storage for all ways with byte-enable writes and write-to-read bypass
`timescale 1ns/1ps

module l1d_data_mem (
	input logic     clk,
	l1d_data_if.mem port
);

	l1d_pkg::l1d_line_u line_ram [l1d_pkg::WAY_NUM][l1d_pkg::SET_NUM];

	// Stored line with the enabled bytes replaced
	l1d_pkg::l1d_line_u wr_merged [l1d_pkg::WAY_NUM];

	always_comb begin
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			wr_merged[w] = line_ram[w][port.wr_idx];
			for (int b = 0; b < l1d_pkg::LINE_BYTES; b++) begin
				if (port.wr_be[b])
					wr_merged[w].bytes[b] = port.wr_line.bytes[b];
			end
		end
	end

	// ----------------------------------------
	// Write and registered read
	// ----------------------------------------
	always_ff @(posedge clk) begin
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (port.wr_way[w])
				line_ram[w][port.wr_idx] <= wr_merged[w];
			if (port.rd_en) begin
				// Same set written this cycle, return new bytes
				if (port.wr_way[w] && (port.wr_idx == port.rd_idx))
					port.rd_lines[w] <= wr_merged[w];
				else
					port.rd_lines[w] <= line_ram[w][port.rd_idx];
			end
		end
	end

endmodule

// File: src/l1d_plru.sv
// Tree pseudo-LRU state per set with hit detection and victim choice
`timescale 1ns/1ps

module l1d_plru (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        lookup,
	input  logic [l1d_pkg::IDX_W-1:0]   idx,
	input  logic [l1d_pkg::WAY_NUM-1:0] hit_vect,
	input  logic [l1d_pkg::WAY_NUM-1:0] val_vect,
	output logic                        hit,
	output logic [l1d_pkg::WAY_NUM-1:0] victim
);

	// Bit 0 picks the pair, bit 1 the way in 0/1, bit 2 the way in 2/3
	logic [l1d_pkg::WAY_NUM-2:0] tree_r [l1d_pkg::SET_NUM];

	logic                        lookup_r;
	logic [l1d_pkg::IDX_W-1:0]   idx_r;
	logic [l1d_pkg::WAY_NUM-1:0] hit_way;
	logic [l1d_pkg::WAY_NUM-1:0] tree_way;
	logic [l1d_pkg::WAY_NUM-1:0] used_way;
	logic [l1d_pkg::WAY_NUM-2:0] tree_cur;
	logic [l1d_pkg::WAY_NUM-2:0] tree_nxt;

	assign hit_way  = hit_vect & val_vect;
	assign hit      = lookup_r & (|hit_way);
	assign tree_cur = tree_r[idx_r];

	// ----------------------------------------
	// Victim choice
	// ----------------------------------------
	always_comb begin
		case ({tree_cur[0], tree_cur[0] ? tree_cur[2] : tree_cur[1]})
			2'b00:   tree_way = 4'b0001;
			2'b01:   tree_way = 4'b0010;
			2'b10:   tree_way = 4'b0100;
			default: tree_way = 4'b1000;
		endcase
	end

	// Lowest invalid way wins over the tree
	always_comb begin
		victim = tree_way;
		for (int w = l1d_pkg::WAY_NUM - 1; w >= 0; w--) begin
			if (!val_vect[w]) begin
				victim    = '0;
				victim[w] = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Tree update
	// ----------------------------------------

	// A cached read miss always fills the victim, so mark it used now
	assign used_way = hit ? hit_way : victim;

	always_comb begin
		tree_nxt = tree_cur;
		if (used_way[0] | used_way[1]) begin
			tree_nxt[0] = 1'b1;
			tree_nxt[1] = used_way[0];
		end else begin
			tree_nxt[0] = 1'b0;
			tree_nxt[2] = used_way[2];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lookup_r <= 1'b0;
			for (int s = 0; s < l1d_pkg::SET_NUM; s++)
				tree_r[s] <= '0;
		end else begin
			lookup_r <= lookup;
			if (lookup_r)
				tree_r[idx_r] <= tree_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup)
			idx_r <= idx;
	end

endmodule

// File: src/l1d_ctrl.sv
// Request pipeline, stall, MAU request forming and core response
`timescale 1ns/1ps

module l1d_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           core_req_val,
	input  logic [l1d_pkg::ADDR_W-1:0]     core_req_addr,
	input  logic [l1d_pkg::COP_W-1:0]      core_req_cop,
	input  logic [l1d_pkg::DATA_W-1:0]     core_req_wdata,
	input  logic [l1d_pkg::SIZE_W-1:0]     core_req_size,
	output logic                           core_req_ack,
	output logic [l1d_pkg::DATA_W-1:0]     core_ack_data,
	output logic                           mau_req_val,
	output logic                           mau_req_nc,
	output logic                           mau_req_we,
	output logic [l1d_pkg::ADDR_W-1:0]     mau_req_addr,
	output logic [l1d_pkg::DATA_W-1:0]     mau_req_wdata,
	output logic [l1d_pkg::DATA_W/8-1:0]   mau_req_be,
	input  logic                           mau_req_ack,
	input  l1d_pkg::l1d_line_u             mau_ack_data,
	l1d_tag_if.ctrl                        tag,
	l1d_data_if.ctrl                       data,
	output logic                           plru_lookup,
	output logic [l1d_pkg::IDX_W-1:0]      plru_idx,
	input  logic                           plru_hit,
	input  logic [l1d_pkg::WAY_NUM-1:0]    plru_victim
);

	logic [l1d_pkg::IDX_W-1:0]          s0_idx;
	logic [l1d_pkg::OFFSET_W-1:0]       s0_off;
	logic                               s0_rd;
	logic                               s0_we;
	logic                               s0_nc;
	logic [l1d_pkg::DATA_W/8-1:0]       s0_be;
	logic                               accept;
	logic                               stall;

	logic                               s1_val_r;
	logic                               s1_first_r;
	logic                               s1_resp_r;
	logic                               s1_we_r;
	logic                               s1_nc_r;
	logic [l1d_pkg::ADDR_W-1:0]         s1_addr_r;
	logic [l1d_pkg::DATA_W-1:0]         s1_wdata_r;
	logic [l1d_pkg::DATA_W/8-1:0]       s1_be_r;
	logic [l1d_pkg::TAG_W-1:0]          s1_tag;
	logic [l1d_pkg::IDX_W-1:0]          s1_idx;
	logic [l1d_pkg::OFFSET_W-1:0]       s1_off;
	logic [l1d_pkg::LINE_BYTES-1:0]     s1_line_be;
	logic [l1d_pkg::WAY_NUM-1:0]        s1_hit_way;
	logic [l1d_pkg::WAY_NUM-1:0]        victim_r;

	logic                               rd_hit;
	logic                               fill;
	logic                               wr_upd;
	l1d_pkg::l1d_line_u                 mau_data_r;
	l1d_pkg::l1d_line_u                 hit_line;
	l1d_pkg::l1d_line_u                 resp_line;
	logic [$clog2(l1d_pkg::LINE_WORDS)-1:0] word_sel;

	// ----------------------------------------
	// Stage 0
	// ----------------------------------------
	assign {s0_idx, s0_off} = core_req_addr[l1d_pkg::IDX_W+l1d_pkg::OFFSET_W-1:0];

	assign s0_rd = (core_req_cop == l1d_pkg::COP_RD);
	assign s0_we = (core_req_cop == l1d_pkg::COP_WR) | (core_req_cop == l1d_pkg::COP_WRNC);
	assign s0_nc = (core_req_cop == l1d_pkg::COP_RDNC) | (core_req_cop == l1d_pkg::COP_WRNC);

	// Size mask moved to the addressed bytes of the word
	always_comb begin
		case (core_req_size)
			l1d_pkg::SIZE_B: s0_be = 4'b0001 << s0_off[1:0];
			l1d_pkg::SIZE_H: s0_be = 4'b0011 << s0_off[1:0];
			default:         s0_be = 4'b1111;
		endcase
	end

	assign accept = core_req_val & ~stall;

	assign tag.rd_en   = accept & ~s0_nc;
	assign tag.rd_idx  = s0_idx;
	assign data.rd_en  = accept & s0_rd;
	assign data.rd_idx = s0_idx;
	assign plru_lookup = accept & s0_rd;
	assign plru_idx    = s0_idx;

	// ----------------------------------------
	// Stage 1
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_val_r   <= 1'b0;
			s1_first_r <= 1'b0;
			s1_resp_r  <= 1'b0;
		end else begin
			if (!stall)
				s1_val_r <= accept;
			s1_first_r <= accept;
			// Read data arrived, answer next cycle
			s1_resp_r  <= s1_val_r & ~s1_we_r & ~s1_resp_r & mau_req_ack;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s1_addr_r  <= core_req_addr;
			s1_we_r    <= s0_we;
			s1_nc_r    <= s0_nc;
			s1_wdata_r <= core_req_wdata;
			s1_be_r    <= s0_be;
		end
		// Tree moves after the first cycle, hold its choice
		if (s1_first_r)
			victim_r <= plru_victim;
		if (mau_req_ack)
			mau_data_r <= mau_ack_data;
	end

	assign {s1_tag, s1_idx, s1_off} = s1_addr_r;
	assign tag.cmp_tag = s1_tag;
	assign s1_hit_way  = tag.hit_vect & tag.val_vect;

	assign rd_hit = s1_val_r & ~s1_we_r & ~s1_nc_r & ~s1_resp_r & plru_hit;
	assign stall  = s1_val_r & (s1_we_r ? ~mau_req_ack : ~(rd_hit | s1_resp_r));
	assign fill   = s1_val_r & ~s1_we_r & ~s1_nc_r & ~s1_resp_r & mau_req_ack;
	assign wr_upd = s1_val_r & s1_we_r & ~s1_nc_r & (|s1_hit_way) & mau_req_ack;

	assign s1_line_be = {{(l1d_pkg::LINE_BYTES - 4){1'b0}}, s1_be_r}
		<< {s1_off[l1d_pkg::OFFSET_W-1:2], 2'b00};

	// ----------------------------------------
	// Array writes
	// ----------------------------------------
	assign tag.wr_way = fill ? victim_r : '0;
	assign tag.wr_idx = s1_idx;
	assign tag.wr_tag = s1_tag;

	always_comb begin
		data.wr_idx = s1_idx;
		if (fill) begin
			data.wr_way  = victim_r;
			data.wr_be   = '1;
			data.wr_line = mau_ack_data;
		end else begin
			data.wr_way        = wr_upd ? s1_hit_way : '0;
			data.wr_be         = s1_line_be;
			data.wr_line.words = {l1d_pkg::LINE_WORDS{s1_wdata_r}};
		end
	end

	// ----------------------------------------
	// MAU request
	// ----------------------------------------
	assign mau_req_val   = s1_val_r & ~s1_resp_r & ~rd_hit;
	assign mau_req_nc    = s1_nc_r;
	assign mau_req_we    = s1_we_r;
	assign mau_req_addr  = (s1_we_r | s1_nc_r) ? s1_addr_r :
		{s1_tag, s1_idx, {l1d_pkg::OFFSET_W{1'b0}}};
	assign mau_req_wdata = s1_wdata_r;
	assign mau_req_be    = s1_be_r;

	// ----------------------------------------
	// Core response
	// ----------------------------------------
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (s1_hit_way[w])
				hit_line = data.rd_lines[w];
		end
	end

	assign resp_line = s1_resp_r ? mau_data_r : hit_line;
	// Uncached reads come back in word 0
	assign word_sel  = (s1_resp_r & s1_nc_r) ? '0 : s1_off[l1d_pkg::OFFSET_W-1:2];

	assign core_ack_data = resp_line.words[word_sel];
	assign core_req_ack  = rd_hit | s1_resp_r | (s1_val_r & s1_we_r & mau_req_ack);

	// ----------------------------------------
	// Assertions
	// ----------------------------------------
	req_when_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val |-> tag.ready)
		else $error("Core request before tag sweep finished");

	word_align_a: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val && (core_req_size == l1d_pkg::SIZE_W4) |-> core_req_addr[1:0] == 2'b00)
		else $error("Word request not aligned to 4 bytes");

	half_align_a: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val && (core_req_size == l1d_pkg::SIZE_H) |-> !core_req_addr[0])
		else $error("Halfword request not aligned to 2 bytes");

	mau_addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_val && !mau_req_ack |=> $stable(mau_req_addr))
		else $error("MAU address changed while waiting for ack");

endmodule

// File: src/l1d_top.sv
// L1 data cache top level with control, arrays and replacement
`timescale 1ns/1ps

module l1d_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         core_req_val,
	input  logic [l1d_pkg::ADDR_W-1:0]   core_req_addr,
	input  logic [l1d_pkg::COP_W-1:0]    core_req_cop,
	input  logic [l1d_pkg::DATA_W-1:0]   core_req_wdata,
	input  logic [l1d_pkg::SIZE_W-1:0]   core_req_size,
	output logic                         ready,
	output logic                         core_req_ack,
	output logic [l1d_pkg::DATA_W-1:0]   core_ack_data,
	output logic                         mau_req_val,
	output logic                         mau_req_nc,
	output logic                         mau_req_we,
	output logic [l1d_pkg::ADDR_W-1:0]   mau_req_addr,
	output logic [l1d_pkg::DATA_W-1:0]   mau_req_wdata,
	output logic [l1d_pkg::DATA_W/8-1:0] mau_req_be,
	input  logic                         mau_req_ack,
	input  l1d_pkg::l1d_line_u           mau_ack_data
);

	l1d_tag_if  tag_if ();
	l1d_data_if data_if ();

	logic                        plru_lookup;
	logic [l1d_pkg::IDX_W-1:0]   plru_idx;
	logic                        plru_hit;
	logic [l1d_pkg::WAY_NUM-1:0] plru_victim;

	assign ready = tag_if.ready;

	l1d_ctrl i_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_val   (core_req_val),
		.core_req_addr  (core_req_addr),
		.core_req_cop   (core_req_cop),
		.core_req_wdata (core_req_wdata),
		.core_req_size  (core_req_size),
		.core_req_ack   (core_req_ack),
		.core_ack_data  (core_ack_data),
		.mau_req_val    (mau_req_val),
		.mau_req_nc     (mau_req_nc),
		.mau_req_we     (mau_req_we),
		.mau_req_addr   (mau_req_addr),
		.mau_req_wdata  (mau_req_wdata),
		.mau_req_be     (mau_req_be),
		.mau_req_ack    (mau_req_ack),
		.mau_ack_data   (mau_ack_data),
		.tag            (tag_if.ctrl),
		.data           (data_if.ctrl),
		.plru_lookup    (plru_lookup),
		.plru_idx       (plru_idx),
		.plru_hit       (plru_hit),
		.plru_victim    (plru_victim)
	);

	l1d_tag_mem i_tag_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.port  (tag_if.mem)
	);

	l1d_data_mem i_data_mem (
		.clk  (clk),
		.port (data_if.mem)
	);

	// Replacement sees the stage 1 tag read directly
	l1d_plru i_plru (
		.clk      (clk),
		.rst_n    (rst_n),
		.lookup   (plru_lookup),
		.idx      (plru_idx),
		.hit_vect (tag_if.hit_vect),
		.val_vect (tag_if.val_vect),
		.hit      (plru_hit),
		.victim   (plru_victim)
	);

endmodule

// File: dv/l1d_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module l1d_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: dv/l1d_mem_model.sv
// MAU responder with backing byte memory and random latency
`timescale 1ns/1ps

module l1d_mem_model (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mau_req_val,
	input  logic                         mau_req_nc,
	input  logic                         mau_req_we,
	input  logic [l1d_pkg::ADDR_W-1:0]   mau_req_addr,
	input  logic [l1d_pkg::DATA_W-1:0]   mau_req_wdata,
	input  logic [l1d_pkg::DATA_W/8-1:0] mau_req_be,
	output logic                         mau_req_ack,
	output l1d_pkg::l1d_line_u           mau_ack_data
);

	logic [7:0] mem [logic [l1d_pkg::ADDR_W-1:0]];

	// Bytes never written hold a pattern of their whole address
	function automatic logic [7:0] read_byte(logic [l1d_pkg::ADDR_W-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[23:20]} ^ a[31:24] ^ 8'h5a;
	endfunction

	initial begin
		int                         latency;
		logic [l1d_pkg::ADDR_W-1:0] base;
		mau_req_ack  = 1'b0;
		mau_ack_data = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mau_req_val) begin
				// Acknowledge 1 to 6 cycles after the request shows up
				latency = 1 + ($urandom % 6);
				repeat (latency) @(posedge clk);
				#1;
				mau_ack_data = '0;
				if (mau_req_we) begin
					base = {mau_req_addr[l1d_pkg::ADDR_W-1:2], 2'b00};
					for (int i = 0; i < 4; i++) begin
						if (mau_req_be[i])
							mem[base + i] = mau_req_wdata[8*i +: 8];
					end
				end else if (mau_req_nc) begin
					// Uncached word goes back in word 0
					base = {mau_req_addr[l1d_pkg::ADDR_W-1:2], 2'b00};
					for (int i = 0; i < 4; i++)
						mau_ack_data.bytes[i] = read_byte(base + i);
				end else begin
					base = {mau_req_addr[l1d_pkg::ADDR_W-1:4], 4'h0};
					for (int i = 0; i < l1d_pkg::LINE_BYTES; i++)
						mau_ack_data.bytes[i] = read_byte(base + i);
				end
				mau_req_ack = 1'b1;
				@(posedge clk);
				#1;
				mau_req_ack = 1'b0;
			end
		end
	end

endmodule

// File: dv/l1d_tb.sv
// Testbench top with random stimulus, reference byte memory and checks
`timescale 1ns/1ps

module l1d_tb;

	localparam int REQ_NUM  = 2000;
	localparam int WAIT_MAX = 50;

	logic                                clk;
	logic                                rst_n;
	logic                                core_req_val;
	logic [l1d_pkg::ADDR_W-1:0]          core_req_addr;
	logic [l1d_pkg::COP_W-1:0]           core_req_cop;
	logic [l1d_pkg::DATA_W-1:0]          core_req_wdata;
	logic [l1d_pkg::SIZE_W-1:0]          core_req_size;
	logic                                ready;
	logic                                core_req_ack;
	logic [l1d_pkg::DATA_W-1:0]          core_ack_data;
	logic                                mau_req_val;
	logic                                mau_req_nc;
	logic                                mau_req_we;
	logic [l1d_pkg::ADDR_W-1:0]          mau_req_addr;
	logic [l1d_pkg::DATA_W-1:0]          mau_req_wdata;
	logic [l1d_pkg::DATA_W/8-1:0]        mau_req_be;
	logic                                mau_req_ack;
	l1d_pkg::l1d_line_u                  mau_ack_data;

	// Reference memory, always current since every write reaches memory
	logic [7:0] ref_mem [logic [l1d_pkg::ADDR_W-1:0]];
	// Lines a cached read has brought in since reset
	bit         filled [logic [l1d_pkg::ADDR_W-5:0]];
	int         errors;

	l1d_clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	l1d_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_val   (core_req_val),
		.core_req_addr  (core_req_addr),
		.core_req_cop   (core_req_cop),
		.core_req_wdata (core_req_wdata),
		.core_req_size  (core_req_size),
		.ready          (ready),
		.core_req_ack   (core_req_ack),
		.core_ack_data  (core_ack_data),
		.mau_req_val    (mau_req_val),
		.mau_req_nc     (mau_req_nc),
		.mau_req_we     (mau_req_we),
		.mau_req_addr   (mau_req_addr),
		.mau_req_wdata  (mau_req_wdata),
		.mau_req_be     (mau_req_be),
		.mau_req_ack    (mau_req_ack),
		.mau_ack_data   (mau_ack_data)
	);

	l1d_mem_model i_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.mau_req_val   (mau_req_val),
		.mau_req_nc    (mau_req_nc),
		.mau_req_we    (mau_req_we),
		.mau_req_addr  (mau_req_addr),
		.mau_req_wdata (mau_req_wdata),
		.mau_req_be    (mau_req_be),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data)
	);

	// ----------------------------------------
	// Reference model helpers
	// ----------------------------------------
	function automatic logic [7:0] ref_byte(logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[23:20]} ^ a[31:24] ^ 8'h5a;
	endfunction

	// Byte lanes of a word touched by an access
	function automatic logic [3:0] lane_mask(logic [2:0] size, logic [1:0] low);
		case (size)
			l1d_pkg::SIZE_B: return 4'b0001 << low;
			l1d_pkg::SIZE_H: return 4'b0011 << low;
			default:         return 4'b1111;
		endcase
	endfunction

	function automatic logic [21:0] tag_for(int k);
		return 22'h00c40 + 22'(k) * 22'h0313;
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		errors++;
		$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	// ----------------------------------------
	// One request from drive to acknowledge
	// ----------------------------------------
	task automatic run_request(logic [1:0] cop, logic [31:0] addr, logic [2:0] size,
		logic [31:0] wdata, bit exp_hit, bit exp_miss);
		logic [3:0]  be;
		logic [31:0] mask;
		logic [31:0] exp_word;
		logic [31:0] word_addr;
		bit          is_wr;
		bit          is_nc;
		bit          acked;
		bit          mau_seen;
		int          n;
		int          ack_n;
		be        = lane_mask(size, addr[1:0]);
		word_addr = {addr[31:2], 2'b00};
		is_wr     = (cop == l1d_pkg::COP_WR) || (cop == l1d_pkg::COP_WRNC);
		is_nc     = (cop == l1d_pkg::COP_RDNC) || (cop == l1d_pkg::COP_WRNC);
		acked     = 1'b0;
		mau_seen  = 1'b0;
		n         = 0;
		ack_n     = -10;
		core_req_val   = 1'b1;
		core_req_addr  = addr;
		core_req_cop   = cop;
		core_req_size  = size;
		core_req_wdata = wdata;
		while (!acked && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
			if (mau_req_val) begin
				mau_seen = 1'b1;
				if (mau_req_we !== is_wr)
					report_mismatch("mau_req_we", mau_req_we, is_wr);
				if (mau_req_nc !== is_nc)
					report_mismatch("mau_req_nc", mau_req_nc, is_nc);
				// Read misses fetch the whole line
				if (!is_wr && !is_nc && mau_req_addr !== {addr[31:4], 4'h0})
					report_mismatch("mau_req_addr", mau_req_addr, {addr[31:4], 4'h0});
				if ((is_wr || is_nc) && mau_req_addr !== addr)
					report_mismatch("mau_req_addr", mau_req_addr, addr);
				if (is_wr && mau_req_be !== be)
					report_mismatch("mau_req_be", mau_req_be, be);
				if (is_wr && mau_req_wdata !== wdata)
					report_mismatch("mau_req_wdata", mau_req_wdata, wdata);
				if (mau_req_ack)
					ack_n = n;
			end
			if (is_wr && core_req_ack !== mau_req_ack)
				report_mismatch("core_req_ack", core_req_ack, mau_req_ack);
			if (core_req_ack === 1'b1) begin
				acked = 1'b1;
				if (!is_wr && mau_seen && n != ack_n + 1)
					report_failure("Read acknowledge not one cycle after the MAU acknowledge");
				if (!is_wr) begin
					mask     = '0;
					exp_word = '0;
					for (int i = 0; i < 4; i++) begin
						if (be[i]) begin
							mask[8*i +: 8]     = 8'hff;
							exp_word[8*i +: 8] = ref_byte(word_addr + i);
						end
					end
					if ((core_ack_data & mask) !== exp_word)
						report_mismatch("core_ack_data", core_ack_data & mask, exp_word);
				end
			end
			@(posedge clk);
			#1;
			// Taken at the first edge because stage 1 is empty
			core_req_val = 1'b0;
		end
		if (!acked)
			report_failure("No core acknowledge before the timeout");
		if (exp_hit && (mau_seen || n != 2))
			report_failure("Repeated cached read did not hit in the next cycle");
		if (exp_miss && !mau_seen)
			report_failure("Read of a line never filled did not go to memory");
		if ((is_wr || is_nc) && !mau_seen)
			report_failure("Write or uncached request did not reach memory");
		if (is_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i])
					ref_mem[word_addr + i] = wdata[8*i +: 8];
			end
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int          r;
		int          n;
		int          gap;
		logic [1:0]  cop;
		logic [2:0]  size;
		logic [3:0]  off;
		logic [21:0] tag;
		logic [5:0]  idx;
		logic [31:0] addr;
		logic [31:0] prev_addr;
		logic [1:0]  prev_cop;
		logic [2:0]  prev_size;
		bit          have_prev;
		bit          exp_hit;
		bit          exp_miss;
		void'($urandom(32'h5393));
		core_req_val   = 1'b0;
		core_req_addr  = '0;
		core_req_cop   = l1d_pkg::COP_RD;
		core_req_wdata = '0;
		core_req_size  = l1d_pkg::SIZE_W4;
		errors    = 0;
		have_prev = 1'b0;
		prev_addr = '0;
		prev_cop  = l1d_pkg::COP_RD;
		prev_size = l1d_pkg::SIZE_W4;

		// Reset and valid sweep
		n = 0;
		while (ready !== 1'b1 && n < l1d_pkg::SET_NUM + 16) begin
			@(negedge clk);
			n++;
			if (core_req_ack !== 1'b0 || mau_req_val !== 1'b0)
				report_failure("Acknowledge or MAU request active before ready");
		end
		if (ready !== 1'b1)
			report_failure("ready did not rise after the tag sweep");
		@(posedge clk);
		#1;

		for (int i = 0; i < REQ_NUM; i++) begin
			r = $urandom % 10;
			if (r < 5)
				cop = l1d_pkg::COP_RD;
			else if (r < 8)
				cop = l1d_pkg::COP_WR;
			else if (r < 9)
				cop = l1d_pkg::COP_RDNC;
			else
				cop = l1d_pkg::COP_WRNC;
			r = $urandom % 3;
			size = (r == 0) ? l1d_pkg::SIZE_B : (r == 1) ? l1d_pkg::SIZE_H : l1d_pkg::SIZE_W4;
			off = 4'($urandom % 16);
			if (size == l1d_pkg::SIZE_H)
				off[0] = 1'b0;
			if (size == l1d_pkg::SIZE_W4)
				off[1:0] = 2'b00;
			// Six cached tags per set exceed the ways, tags 6 and 7 stay uncached
			if (cop == l1d_pkg::COP_WRNC)
				tag = tag_for(6 + int'($urandom % 2));
			else if (cop == l1d_pkg::COP_RDNC)
				tag = tag_for(int'($urandom % 8));
			else
				tag = tag_for(int'($urandom % 6));
			idx  = 6'(($urandom % 4) * 13);
			addr = {tag, idx, off};
			// Repeat the last cached address now and then
			if (have_prev && cop[1] == 1'b0 && prev_cop[1] == 1'b0 && ($urandom % 4) == 0) begin
				addr = prev_addr;
				size = prev_size;
			end
			exp_hit  = (cop == l1d_pkg::COP_RD) && have_prev &&
				(prev_cop == l1d_pkg::COP_RD) && (prev_addr[31:4] == addr[31:4]);
			exp_miss = (cop == l1d_pkg::COP_RD) && !filled.exists(addr[31:4]);
			run_request(cop, addr, size, $urandom, exp_hit, exp_miss);
			if (cop == l1d_pkg::COP_RD)
				filled[addr[31:4]] = 1'b1;
			prev_addr = addr;
			prev_cop  = cop;
			prev_size = size;
			have_prev = 1'b1;
			// Idle cycles between requests stay quiet
			gap = $urandom % 3;
			repeat (gap) begin
				@(negedge clk);
				if (core_req_ack !== 1'b0 || mau_req_val !== 1'b0)
					report_failure("Acknowledge or MAU request with no request in flight");
				@(posedge clk);
				#1;
			end
		end

		$display("Requests: %0d, errors: %0d", REQ_NUM, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: vlog.f
src/l1d_pkg.sv
src/l1d_arrays_if.sv
src/l1d_tag_mem.sv
src/l1d_data_mem.sv
src/l1d_plru.sv
src/l1d_ctrl.sv
src/l1d_top.sv
dv/l1d_clk_gen.sv
dv/l1d_mem_model.sv
dv/l1d_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := l1d_tb
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"

$(BUILD)/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
